// File: hw/wb_pkg.sv
package wb_pkg;

    // Datapath widths
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // Value held in the pc field after reset
    localparam logic [DATA_WIDTH-1:0] RESET_PC = 32'h8000_0000;

    // Link values are pc plus one instruction
    localparam logic [DATA_WIDTH-1:0] PC_STEP = 32'd4;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Source of the value written back to rd
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_PC4  = 2'b01,
        WB_ALU  = 2'b10,
        WB_MEM  = 2'b11
    } wb_sel_e;

    // Load width and extension, encoded as funct3
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_fmt_e;

endpackage

// File: hw/wb_ctrl.sv
module wb_ctrl (
    input  logic                          valid_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0] inst_i,
    output logic                          rf_we_o,
    output wb_pkg::wb_sel_e               wb_sel_o,
    output wb_pkg::load_fmt_e             load_fmt_o
);

    wb_pkg::opcode_e opcode;
    logic [2:0]      funct3;

    // Instruction fields used by write-back
    assign opcode = wb_pkg::opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];

    // Result source by opcode
    always_comb begin
        case (opcode)
            wb_pkg::OP_LUI,
            wb_pkg::OP_AUIPC,
            wb_pkg::OP_IMM,
            wb_pkg::OP_REG: begin
                wb_sel_o = wb_pkg::WB_ALU;
            end
            wb_pkg::OP_JAL,
            wb_pkg::OP_JALR: begin
                wb_sel_o = wb_pkg::WB_PC4;
            end
            wb_pkg::OP_LOAD: begin
                wb_sel_o = wb_pkg::WB_MEM;
            end
            // Stores, branches, SYSTEM and unknown opcodes write nothing
            default: begin
                wb_sel_o = wb_pkg::WB_NONE;
            end
        endcase
    end

    // Bubbles never write
    always_comb begin
        if (valid_i && wb_sel_o != wb_pkg::WB_NONE) begin
            rf_we_o = 1'b1;
        end else begin
            rf_we_o = 1'b0;
        end
    end

    // Load format straight from funct3
    always_comb begin
        case (funct3)
            3'b000: begin
                load_fmt_o = wb_pkg::LD_B;
            end
            3'b001: begin
                load_fmt_o = wb_pkg::LD_H;
            end
            3'b100: begin
                load_fmt_o = wb_pkg::LD_BU;
            end
            3'b101: begin
                load_fmt_o = wb_pkg::LD_HU;
            end
            // 3'b010 and the reserved codes load a full word
            default: begin
                load_fmt_o = wb_pkg::LD_W;
            end
        endcase
    end

endmodule

// File: hw/wb_pipe_reg.sv
module wb_pipe_reg #(
    parameter int                    DATA_WIDTH = 32,
    parameter logic [DATA_WIDTH-1:0] RESET_PC   = '0
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              valid_i,
    input  logic [DATA_WIDTH-1:0]             pc_i,
    input  logic [DATA_WIDTH-1:0]             inst_i,
    input  logic [DATA_WIDTH-1:0]             result_i,
    input  logic [DATA_WIDTH-1:0]             dmem_rdata_i,
    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] rd_addr_i,
    output logic                              valid_o,
    output logic [DATA_WIDTH-1:0]             pc_o,
    output logic [DATA_WIDTH-1:0]             inst_o,
    output logic [DATA_WIDTH-1:0]             result_o,
    output logic [DATA_WIDTH-1:0]             dmem_rdata_o,
    output logic [wb_pkg::REG_ADDR_WIDTH-1:0] rd_addr_o
);

    // Control fields
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            pc_o      <= RESET_PC;
            inst_o    <= '0;
            rd_addr_o <= '0;
        end else begin
            valid_o   <= valid_i;
            pc_o      <= pc_i;
            inst_o    <= inst_i;
            rd_addr_o <= rd_addr_i;
        end
    end

    // Payload, captured every cycle
    always_ff @(posedge clk) begin
        result_o     <= result_i;
        dmem_rdata_o <= dmem_rdata_i;
    end

endmodule

// File: hw/wb_result_sel.sv
module wb_result_sel (
    input  logic [wb_pkg::DATA_WIDTH-1:0] pc_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0] result_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0] dmem_rdata_i,
    input  wb_pkg::wb_sel_e               wb_sel_i,
    input  wb_pkg::load_fmt_e             load_fmt_i,
    output logic [wb_pkg::DATA_WIDTH-1:0] wb_data_o
);

    localparam int DW = wb_pkg::DATA_WIDTH;

    logic [DW-1:0] pc_plus4;
    logic [4:0]    byte_shift;
    logic [DW-1:0] load_word;
    logic [DW-1:0] load_data;

    // Link address for JAL and JALR
    assign pc_plus4 = pc_i + wb_pkg::PC_STEP;

    // result_i carries the load address, low bits pick the lane
    assign byte_shift = {result_i[1:0], 3'b000};
    assign load_word  = dmem_rdata_i >> byte_shift;

    always_comb begin
        case (load_fmt_i)
            wb_pkg::LD_B: begin
                load_data = {{(DW - 8){load_word[7]}}, load_word[7:0]};
            end
            wb_pkg::LD_H: begin
                load_data = {{(DW - 16){load_word[15]}}, load_word[15:0]};
            end
            wb_pkg::LD_BU: begin
                load_data = {{(DW - 8){1'b0}}, load_word[7:0]};
            end
            wb_pkg::LD_HU: begin
                load_data = {{(DW - 16){1'b0}}, load_word[15:0]};
            end
            default: begin
                load_data = load_word;
            end
        endcase
    end

    // Write-back mux
    always_comb begin
        case (wb_sel_i)
            wb_pkg::WB_PC4: begin
                wb_data_o = pc_plus4;
            end
            wb_pkg::WB_ALU: begin
                wb_data_o = result_i;
            end
            wb_pkg::WB_MEM: begin
                wb_data_o = load_data;
            end
            default: begin
                wb_data_o = '0;
            end
        endcase
    end

endmodule

// File: hw/reg_file.sv
module reg_file #(
    parameter int ADDR_WIDTH = 5
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          we_i,
    input  logic [ADDR_WIDTH-1:0]         waddr_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [ADDR_WIDTH-1:0]         raddr1_i,
    input  logic [ADDR_WIDTH-1:0]         raddr2_i,
    output logic [wb_pkg::DATA_WIDTH-1:0] rdata1_o,
    output logic [wb_pkg::DATA_WIDTH-1:0] rdata2_o
);

    localparam int NUM_REGS = 2 ** ADDR_WIDTH;

    logic [wb_pkg::DATA_WIDTH-1:0] regs [NUM_REGS];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads, a same-cycle write shows up after the edge
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

// File: hw/wb_top.sv
module wb_top (
    input  logic                              clk,
    input  logic                              rst_i,
    // MEM stage results
    input  logic                              valid_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0]     pc_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0]     inst_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0]     result_i,
    input  logic [wb_pkg::DATA_WIDTH-1:0]     dmem_rdata_i,
    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] rd_addr_i,
    // Decode read ports
    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [wb_pkg::DATA_WIDTH-1:0]     rdata1_o,
    output logic [wb_pkg::DATA_WIDTH-1:0]     rdata2_o,
    // Write port, also visible outside
    output logic                              rf_we_o,
    output logic [wb_pkg::REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic [wb_pkg::DATA_WIDTH-1:0]     wb_data_o
);

    logic                          wb_valid;
    logic [wb_pkg::DATA_WIDTH-1:0] wb_pc;
    logic [wb_pkg::DATA_WIDTH-1:0] wb_inst;
    logic [wb_pkg::DATA_WIDTH-1:0] wb_result;
    logic [wb_pkg::DATA_WIDTH-1:0] wb_dmem_rdata;
    wb_pkg::wb_sel_e               wb_sel;
    wb_pkg::load_fmt_e             wb_load_fmt;

    wb_pipe_reg #(
        .DATA_WIDTH (wb_pkg::DATA_WIDTH),
        .RESET_PC   (wb_pkg::RESET_PC)
    ) u_wb_pipe_reg (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .result_i     (result_i),
        .dmem_rdata_i (dmem_rdata_i),
        .rd_addr_i    (rd_addr_i),
        .valid_o      (wb_valid),
        .pc_o         (wb_pc),
        .inst_o       (wb_inst),
        .result_o     (wb_result),
        .dmem_rdata_o (wb_dmem_rdata),
        .rd_addr_o    (rd_addr_o)
    );

    wb_ctrl u_wb_ctrl (
        .valid_i    (wb_valid),
        .inst_i     (wb_inst),
        .rf_we_o    (rf_we_o),
        .wb_sel_o   (wb_sel),
        .load_fmt_o (wb_load_fmt)
    );

    wb_result_sel u_wb_result_sel (
        .pc_i         (wb_pc),
        .result_i     (wb_result),
        .dmem_rdata_i (wb_dmem_rdata),
        .wb_sel_i     (wb_sel),
        .load_fmt_i   (wb_load_fmt),
        .wb_data_o    (wb_data_o)
    );

    reg_file #(
        .ADDR_WIDTH (wb_pkg::REG_ADDR_WIDTH)
    ) u_reg_file (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (rf_we_o),
        .waddr_i  (rd_addr_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (raddr1_i),
        .raddr2_i (raddr2_i),
        .rdata1_o (rdata1_o),
        .rdata2_o (rdata2_o)
    );

endmodule

// File: test/wb_top_properties.sv
module wb_top_properties (
    input logic            clk,
    input logic            rst_i,
    input logic            rf_we_i,
    input logic            valid_i,
    input wb_pkg::wb_sel_e wb_sel_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Failures so far, added to the testbench totals
    int assert_fails = 0;

    // Pipeline register leaves reset holding a bubble
    we_low_after_reset: assert property (@(posedge clk) rst_i |=> !rf_we_i)
        else begin
            $error("write enable high in the cycle after reset");
            assert_fails++;
        end

    we_needs_valid: assert property (@(posedge clk) disable iff (rst_i) rf_we_i |-> valid_i)
        else begin
            $error("write enable high for a bubble");
            assert_fails++;
        end

    none_never_writes: assert property (
        @(posedge clk) disable iff (rst_i) wb_sel_i == wb_pkg::WB_NONE |-> !rf_we_i)
        else begin
            $error("write enable high with no write-back source");
            assert_fails++;
        end

endmodule

bind wb_top wb_top_properties u_wb_top_properties (
    .clk      (clk),
    .rst_i    (rst_i),
    .rf_we_i  (rf_we_o),
    .valid_i  (wb_valid),
    .wb_sel_i (wb_sel)
);

// File: test/tb_wb_top.sv
module tb_wb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int         FALL_TIMEOUT = 8;
    localparam logic [6:0] OP_ILLEGAL   = 7'b1111111;

    logic        clk;
    logic        rst_i;
    logic        valid_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic [31:0] result_i;
    logic [31:0] dmem_rdata_i;
    logic [4:0]  rd_addr_i;
    logic [4:0]  raddr1_i;
    logic [4:0]  raddr2_i;
    logic [31:0] rdata1_o;
    logic [31:0] rdata2_o;
    logic        rf_we_o;
    logic [4:0]  rd_addr_o;
    logic [31:0] wb_data_o;

    logic [31:0] lfsr;
    logic [31:0] model_regs [32];
    int          fall_cnt;
    int          checks;
    int          errors;
    int          test_errors;
    string       test_name;

    wb_top u_wb_top (.*);

    initial begin
        clk = 1'b0;
        fall_cnt = 0;
        forever begin
            #2 clk = 1'b1;
            #2 clk = 1'b0;
            fall_cnt++;
        end
    end

    // Galois LFSR, stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Weighted opcode table
    // Slots 0 to 3 are ALU types, 4 and 5 jumps, 6 to 9 loads, the rest never write
    function automatic logic [6:0] op_at(input int slot);
        case (slot)
            0: return wb_pkg::OP_LUI;
            1: return wb_pkg::OP_AUIPC;
            2: return wb_pkg::OP_IMM;
            3: return wb_pkg::OP_REG;
            4: return wb_pkg::OP_JAL;
            5: return wb_pkg::OP_JALR;
            6, 7, 8, 9: return wb_pkg::OP_LOAD;
            10, 13: return wb_pkg::OP_STORE;
            11, 14: return wb_pkg::OP_BRANCH;
            12: return wb_pkg::OP_SYSTEM;
            default: return OP_ILLEGAL;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // Returns half a nanosecond after the next falling edge
    task automatic next_fall();
        int start;
        int polls;
        start = fall_cnt;
        polls = 0;
        while (fall_cnt == start && polls < FALL_TIMEOUT) begin
            #1;
            polls++;
        end
        if (fall_cnt == start) begin
            $display("Timeout: the clock did not fall within %0d ns", FALL_TIMEOUT);
            $display("CHECKS FAILED");
            $finish;
        end
    endtask

    // The inputs still held are the ones now in the pipeline register
    task automatic predict_wb(output logic we, output logic [31:0] data);
        logic [31:0] word;
        word = dmem_rdata_i >> (8 * result_i[1:0]);
        we = valid_i;
        case (inst_i[6:0])
            wb_pkg::OP_LUI, wb_pkg::OP_AUIPC, wb_pkg::OP_IMM, wb_pkg::OP_REG: begin
                data = result_i;
            end
            wb_pkg::OP_JAL, wb_pkg::OP_JALR: begin
                data = pc_i + 32'd4;
            end
            wb_pkg::OP_LOAD: begin
                case (inst_i[14:12])
                    3'b000: data = {{24{word[7]}}, word[7:0]};
                    3'b001: data = {{16{word[15]}}, word[15:0]};
                    3'b100: data = {24'h0, word[7:0]};
                    3'b101: data = {16'h0, word[15:0]};
                    default: data = word;
                endcase
            end
            default: begin
                we = 1'b0;
                data = '0;
            end
        endcase
    endtask

    // Check what the last edge produced, then present the next instruction
    task automatic cycle(input logic v, input logic [31:0] inst, input logic [31:0] pc,
                         input logic [31:0] res, input logic [31:0] dmem,
                         input logic [4:0] ra1, input logic [4:0] ra2);
        logic        we_exp;
        logic [31:0] data_exp;
        next_fall();
        check_value("rdata1_o", model_regs[raddr1_i], rdata1_o);
        check_value("rdata2_o", model_regs[raddr2_i], rdata2_o);
        predict_wb(we_exp, data_exp);
        check_value("rf_we_o", {31'b0, we_exp}, {31'b0, rf_we_o});
        check_value("rd_addr_o", {27'b0, rd_addr_i}, {27'b0, rd_addr_o});
        check_value("wb_data_o", data_exp, wb_data_o);
        // x0 ignores writes
        if (we_exp && rd_addr_i != 5'd0) begin
            model_regs[rd_addr_i] = data_exp;
        end
        valid_i = v;
        inst_i = inst;
        pc_i = pc;
        result_i = res;
        dmem_rdata_i = dmem;
        rd_addr_i = inst[11:7];
        raddr1_i = ra1;
        raddr2_i = ra2;
    endtask

    // Read port 1 follows the previous rd so each write is read back
    task automatic send_random(input int lo, input int hi, input logic v);
        logic [6:0]  op;
        logic [16:0] upper;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [29:0] pc_word;
        logic [31:0] res;
        logic [31:0] dmem;
        logic [4:0]  ra2;
        op = op_at(lo + take_bits(4) % (hi - lo + 1));
        upper = 17'(take_bits(17));
        funct3 = 3'(take_bits(3));
        rd = 5'(take_bits(5));
        pc_word = 30'(take_bits(30));
        res = take_bits(32);
        dmem = take_bits(32);
        ra2 = 5'(take_bits(5));
        cycle(v, {upper, funct3, rd, op}, {pc_word, 2'b00}, res, dmem, rd_addr_i, ra2);
    endtask

    task automatic sweep_regs();
        logic [4:0] addr;
        addr = '0;
        repeat (33) begin
            cycle(1'b0, '0, wb_pkg::RESET_PC, '0, '0, addr, ~addr);
            addr++;
        end
    endtask

    task automatic finish_test();
        $display("test %s done, %0d mismatches", test_name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        lfsr = 32'hc740_8255;
        checks = 0;
        errors = 0;
        test_errors = 0;
        rst_i = 1'b1;
        valid_i = 1'b0;
        pc_i = wb_pkg::RESET_PC;
        inst_i = '0;
        result_i = '0;
        dmem_rdata_i = '0;
        rd_addr_i = '0;
        raddr1_i = '0;
        raddr2_i = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // Stay off the clock edges by half a nanosecond
        #0.5;
        repeat (2) next_fall();
        rst_i = 1'b0;
        test_name = "reset";
        check_value("rf_we_o", 32'h0, {31'b0, rf_we_o});
        sweep_regs();
        finish_test();
        test_name = "alu";
        repeat (60) send_random(0, 3, 1'b1);
        sweep_regs();
        finish_test();
        test_name = "jump";
        repeat (30) send_random(4, 5, 1'b1);
        finish_test();
        test_name = "load";
        repeat (80) send_random(6, 9, 1'b1);
        finish_test();
        test_name = "no_write";
        repeat (40) send_random(10, 15, 1'b1);
        repeat (40) send_random(0, 15, 1'b0);
        cycle(1'b1, {25'h0, wb_pkg::OP_IMM}, '0, 32'hdead_beef, '0, 5'd0, 5'd0);
        sweep_regs();
        finish_test();
        test_name = "mixed";
        repeat (300) send_random(0, 15, take_bits(3) != 32'd0);
        finish_test();
        test_name = "random";
        repeat (2000) send_random(0, 15, 1'b1);
        sweep_regs();
        finish_test();
        errors += u_wb_top.u_wb_top_properties.assert_fails;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hw/wb_pkg.sv
hw/wb_ctrl.sv
hw/wb_pipe_reg.sv
hw/wb_result_sel.sv
hw/reg_file.sv
hw/wb_top.sv
test/wb_top_properties.sv
test/tb_wb_top.sv
